// File: Bender.yml
package:
  name: cdc_mbox

sources:
  - verilog/cdc_mbox_pkg.sv
  - verilog/prim_flop_2sync.sv
  - verilog/prim_sync_reqack.sv
  - verilog/cdc_mbox_channel.sv
  - verilog/cdc_mbox_dispatcher.sv
  - verilog/cdc_mbox_wb_drainer.sv
  - verilog/cdc_mbox_top.sv
  - target: test
    files:
      - verif/tb_cdc_mbox.sv

// File: src.f
verilog/cdc_mbox_pkg.sv
verilog/prim_flop_2sync.sv
verilog/prim_sync_reqack.sv
verilog/cdc_mbox_channel.sv
verilog/cdc_mbox_dispatcher.sv
verilog/cdc_mbox_wb_drainer.sv
verilog/cdc_mbox_top.sv
verif/tb_cdc_mbox.sv

// File: verif/cdc_mbox_testdata.txt
// Mailbox events, all fields hex, one event per line
// Columns: channel index, data word, idle gap in source cycles
0 1a01 02
1 2b02 00
2 3c03 00
3 4d04 03
0 5e05 00
0 5e06 00
2 7001 00
2 7002 00
2 7003 00
2 7004 00
2 7005 00
2 7006 00
2 7007 00
2 7008 04
1 8101 00
3 8303 00
1 8102 00
3 8304 00
0 9000 01
1 ffff 00
2 0000 00
3 a5a5 06
0 5a5a 00

// File: verif/tb_cdc_mbox.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cdc_mbox;

  // Up to this many events in the data file, three fields each
  localparam int MaxEntries = 64;
  localparam int EntryWidth = cdc_mbox_pkg::ChanIdxWidth + cdc_mbox_pkg::DataWidth;

  logic                    clk_src_i;
  logic                    rst_src_ni;
  logic                    clk_dst_i;
  logic                    rst_dst_ni;
  logic                    src_valid_i;
  cdc_mbox_pkg::chan_idx_t src_chan_i;
  cdc_mbox_pkg::data_t     src_data_i;
  logic                    src_ready_o;
  logic                    wb_cyc_o;
  logic                    wb_stb_o;
  logic                    wb_we_o;
  cdc_mbox_pkg::chan_idx_t wb_adr_o;
  cdc_mbox_pkg::data_t     wb_dat_o;
  logic                    wb_ack_i;

  // Raw test data, channel, word and gap per event
  logic [15:0] td_mem [0:3*MaxEntries-1];
  int          num_entries = 0;

  // Accepted events still waiting for their write, {channel, word}
  logic [EntryWidth-1:0] exp_q [$];

  int   accepted     = 0;
  int   write_count  = 0;
  int   value_errors = 0;
  int   other_errors = 0;
  int   seed         = 70398;
  logic saw_stall    = 1'b0;

  // Bus cycle tracking for the stability check
  logic                    in_cycle = 1'b0;
  cdc_mbox_pkg::chan_idx_t held_adr;
  cdc_mbox_pkg::data_t     held_dat;

  cdc_mbox_top i_cdc_mbox_top (
    .clk_src_i   (clk_src_i),
    .rst_src_ni  (rst_src_ni),
    .clk_dst_i   (clk_dst_i),
    .rst_dst_ni  (rst_dst_ni),
    .src_valid_i (src_valid_i),
    .src_chan_i  (src_chan_i),
    .src_data_i  (src_data_i),
    .src_ready_o (src_ready_o),
    .wb_cyc_o    (wb_cyc_o),
    .wb_stb_o    (wb_stb_o),
    .wb_we_o     (wb_we_o),
    .wb_adr_o    (wb_adr_o),
    .wb_dat_o    (wb_dat_o),
    .wb_ack_i    (wb_ack_i)
  );

  // Destination clock, 100 ns
  initial begin
    clk_dst_i = 1'b0;
    forever #50 clk_dst_i = ~clk_dst_i;
  end

  // Source clock, 70 ns
  initial begin
    clk_src_i = 1'b0;
    forever #35 clk_src_i = ~clk_src_i;
  end

  // Closing summary and verdict
  task automatic finish_run();
    $display("Summary: writes %0d of %0d, value errors %0d, other errors %0d",
             write_count, num_entries, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  endtask

  // Match one completed write against the oldest event of its channel
  task automatic check_write(input cdc_mbox_pkg::chan_idx_t adr,
                             input cdc_mbox_pkg::data_t dat);
    int idx;
    cdc_mbox_pkg::data_t expected;
    idx = -1;
    for (int i = 0; i < exp_q.size(); i++) begin
      if (idx < 0 && exp_q[i][cdc_mbox_pkg::DataWidth +: cdc_mbox_pkg::ChanIdxWidth] == adr) begin
        idx = i;
      end
    end
    write_count++;
    assert (wb_we_o === 1'b1) else begin
      value_errors++;
      $display("Fail at %0t: wb_we_o = %b, expected 1", $time, wb_we_o);
    end
    assert (idx >= 0) else begin
      other_errors++;
      $display("Write at %0t to channel %0d with no event waiting", $time, adr);
    end
    if (idx >= 0) begin
      expected = exp_q[idx][cdc_mbox_pkg::DataWidth-1:0];
      // Oldest entry of this channel, so per-channel order is enforced
      assert (dat === expected) else begin
        value_errors++;
        $display("Fail at %0t: wb_dat_o = %h, expected %h", $time, dat, expected);
      end
      exp_q.delete(idx);
    end
  endtask

  // Wishbone slave, ack after a random 0 to 5 cycle wait
  initial begin : wb_slave
    int wait_cycles;
    wb_ack_i = 1'b0;
    forever begin
      @(posedge clk_dst_i);
      if (rst_dst_ni && wb_cyc_o && wb_stb_o && !wb_ack_i) begin
        wait_cycles = {$random(seed)} % 6;
        repeat (wait_cycles) @(posedge clk_dst_i);
        #5;
        wb_ack_i = 1'b1;
        // Single ack cycle, master drops cyc on the following edge
        @(posedge clk_dst_i);
        #5;
        wb_ack_i = 1'b0;
      end
    end
  end

  // Bus monitor, values seen at the edge are the pre-edge ones
  always @(posedge clk_dst_i) begin
    if (rst_dst_ni && wb_cyc_o && wb_stb_o) begin
      if (!in_cycle) begin
        in_cycle = 1'b1;
        held_adr = wb_adr_o;
        held_dat = wb_dat_o;
      end else begin
        // Address and data must not move during the cycle
        assert (wb_adr_o === held_adr) else begin
          value_errors++;
          $display("Fail at %0t: wb_adr_o = %h, expected %h", $time, wb_adr_o, held_adr);
        end
        assert (wb_dat_o === held_dat) else begin
          value_errors++;
          $display("Fail at %0t: wb_dat_o = %h, expected %h", $time, wb_dat_o, held_dat);
        end
      end
      if (wb_ack_i) begin
        check_write(wb_adr_o, wb_dat_o);
        in_cycle = 1'b0;
      end
    end
  end

  // Run limit grows with the event count
  initial begin : watchdog
    int cycles;
    int limit;
    cycles = 0;
    @(posedge clk_dst_i);
    limit = 60 * num_entries + 100;
    while (cycles < limit) begin
      @(posedge clk_dst_i);
      cycles++;
    end
    other_errors++;
    $display("Timeout after %0d destination cycles, writes still missing", limit);
    finish_run();
  end

  // Reset, source driver and final checks
  initial begin : main
    int wait_cnt;
    int gap;
    rst_src_ni  = 1'b0;
    rst_dst_ni  = 1'b0;
    src_valid_i = 1'b0;
    src_chan_i  = '0;
    src_data_i  = '0;

    $readmemh("verif/cdc_mbox_testdata.txt", td_mem);
    while (num_entries < MaxEntries && !$isunknown(td_mem[3*num_entries+2])) begin
      num_entries++;
    end
    assert (num_entries > 0) else begin
      other_errors++;
      $display("Test data file is missing or holds no events");
    end

    repeat (8) @(posedge clk_dst_i);
    #5;

    // No room reported while the FIFO is held in reset
    assert (src_ready_o === 1'b0) else begin
      value_errors++;
      $display("Fail at %0t: src_ready_o = %b, expected 0", $time, src_ready_o);
    end

    rst_src_ni = 1'b1;
    rst_dst_ni = 1'b1;

    // Bus idle out of reset
    assert (wb_cyc_o === 1'b0) else begin
      value_errors++;
      $display("Fail at %0t: wb_cyc_o = %b, expected 0", $time, wb_cyc_o);
    end
    assert (wb_stb_o === 1'b0) else begin
      value_errors++;
      $display("Fail at %0t: wb_stb_o = %b, expected 0", $time, wb_stb_o);
    end

    // Ready comes up a cycle after reset
    wait_cnt = 0;
    while (src_ready_o !== 1'b1 && wait_cnt < 10) begin
      @(posedge clk_src_i);
      wait_cnt++;
    end
    assert (src_ready_o === 1'b1) else begin
      other_errors++;
      $display("src_ready_o did not rise after reset");
    end

    @(posedge clk_src_i);
    #5;
    for (int i = 0; i < num_entries; i++) begin
      src_chan_i  = cdc_mbox_pkg::chan_idx_t'(td_mem[3*i]);
      src_data_i  = td_mem[3*i+1];
      src_valid_i = 1'b1;
      gap         = td_mem[3*i+2];
      @(posedge clk_src_i);
      // Hold the event until the FIFO has room
      while (src_ready_o !== 1'b1) begin
        saw_stall = 1'b1;
        @(posedge clk_src_i);
      end
      exp_q.push_back({src_chan_i, src_data_i});
      accepted++;
      #5;
      src_valid_i = 1'b0;
      repeat (gap) begin
        @(posedge clk_src_i);
        #5;
      end
    end

    // Drain, then some idle time to catch stray writes
    while (write_count < accepted) @(posedge clk_dst_i);
    repeat (30) @(posedge clk_dst_i);

    assert (exp_q.size() == 0) else begin
      other_errors++;
      $display("%0d accepted events never reached the bus", exp_q.size());
    end
    assert (write_count == num_entries) else begin
      value_errors++;
      $display("Fail at %0t: write count = %0d, expected %0d", $time, write_count, num_entries);
    end
    assert (saw_stall) else begin
      other_errors++;
      $display("src_ready_o never fell during the bursts");
    end
    finish_run();
  end

endmodule

`default_nettype wire

// File: verilog/cdc_mbox_channel.sv
`timescale 1ns/1ps
`default_nettype none

module cdc_mbox_channel (
  input  logic                clk_src_i,
  input  logic                rst_src_ni,
  input  logic                clk_dst_i,
  input  logic                rst_dst_ni,
  // Source domain
  input  logic                load_i,
  input  cdc_mbox_pkg::data_t data_i,
  output logic                busy_o,
  // Destination domain
  output logic                pending_o,
  output cdc_mbox_pkg::data_t word_o,
  input  logic                ack_i
);

  logic                busy_q;
  logic                src_ack;
  cdc_mbox_pkg::data_t word_q;

  // Busy is the request level itself
  prim_sync_reqack i_sync_reqack (
    .clk_src_i  (clk_src_i),
    .rst_src_ni (rst_src_ni),
    .clk_dst_i  (clk_dst_i),
    .rst_dst_ni (rst_dst_ni),
    .src_req_i  (busy_q),
    .src_ack_o  (src_ack),
    .dst_req_o  (pending_o),
    .dst_ack_i  (ack_i)
  );

  // Set on load, cleared by the returning ACK pulse
  always_ff @(posedge clk_src_i or negedge rst_src_ni) begin
    if (!rst_src_ni) begin
      busy_q <= 1'b0;
    end else if (load_i) begin
      busy_q <= 1'b1;
    end else if (src_ack) begin
      busy_q <= 1'b0;
    end
  end

  // Word only changes on load, never while the request is in flight
  always_ff @(posedge clk_src_i) begin
    if (load_i) begin
      word_q <= data_i;
    end
  end

  assign busy_o = busy_q;

  // Read directly by the destination, valid while pending is high
  assign word_o = word_q;

endmodule

`default_nettype wire

// File: verilog/cdc_mbox_dispatcher.sv
`timescale 1ns/1ps
`default_nettype none

module cdc_mbox_dispatcher #(
  parameter int Depth = 4
) (
  input  logic                      clk_src_i,
  input  logic                      rst_src_ni,
  // Event input
  input  logic                      src_valid_i,
  input  cdc_mbox_pkg::chan_idx_t   src_chan_i,
  input  cdc_mbox_pkg::data_t       src_data_i,
  output logic                      src_ready_o,
  // Channel side
  output cdc_mbox_pkg::chan_vec_t   load_o,
  output cdc_mbox_pkg::data_t       data_o,
  input  cdc_mbox_pkg::chan_vec_t   busy_i
);

  localparam int PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntWidth = $clog2(Depth + 1);

  // Entry storage
  cdc_mbox_pkg::chan_idx_t chan_mem [Depth];
  cdc_mbox_pkg::data_t     data_mem [Depth];

  logic [PtrWidth-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntWidth-1:0] count_q, count_d;
  logic                ready_q;
  logic                push, pop;
  cdc_mbox_pkg::chan_idx_t head_chan;

  assign head_chan = chan_mem[rd_ptr_q];
  assign data_o    = data_mem[rd_ptr_q];

  // Accept only when there was room at the last edge
  assign push = src_valid_i && ready_q;
  // Head leaves only if its target slot is free, else the queue waits
  assign pop  = (count_q != '0) && !busy_i[head_chan];

  // One-hot strobe to the head's slot
  assign load_o = pop ? (cdc_mbox_pkg::chan_vec_t'(1) << head_chan) : '0;

  always_comb begin
    count_d = count_q;
    if (push && !pop) begin
      count_d = count_q + 1'b1;
    end else if (pop && !push) begin
      count_d = count_q - 1'b1;
    end
  end

  always_ff @(posedge clk_src_i or negedge rst_src_ni) begin
    if (!rst_src_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      ready_q  <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_d;
      // Ready drops once the queue is full
      ready_q <= (count_d != CntWidth'(Depth));
    end
  end

  always_ff @(posedge clk_src_i) begin
    if (push) begin
      chan_mem[wr_ptr_q] <= src_chan_i;
      data_mem[wr_ptr_q] <= src_data_i;
    end
  end

  assign src_ready_o = ready_q;

endmodule

`default_nettype wire

// File: verilog/cdc_mbox_pkg.sv
`default_nettype none

package cdc_mbox_pkg;

  // Number of mailbox slots
  localparam int NumChannels = 4;

  // Mailbox word width
  localparam int DataWidth = 16;

  // Channel number width, also the Wishbone address width
  localparam int ChanIdxWidth = 2;

  // Payload word on the source input, in the slots and on the bus
  typedef logic [DataWidth-1:0] data_t;

  // Channel number on the source input and Wishbone address
  typedef logic [ChanIdxWidth-1:0] chan_idx_t;

  // One bit per channel: load strobes, busy, pending, ACK pulses
  typedef logic [NumChannels-1:0] chan_vec_t;

endpackage

`default_nettype wire

// File: verilog/cdc_mbox_top.sv
`timescale 1ns/1ps
`default_nettype none

module cdc_mbox_top (
  input  logic                    clk_src_i,
  input  logic                    rst_src_ni,
  input  logic                    clk_dst_i,
  input  logic                    rst_dst_ni,
  // Source events
  input  logic                    src_valid_i,
  input  cdc_mbox_pkg::chan_idx_t src_chan_i,
  input  cdc_mbox_pkg::data_t     src_data_i,
  output logic                    src_ready_o,
  // Wishbone master
  output logic                    wb_cyc_o,
  output logic                    wb_stb_o,
  output logic                    wb_we_o,
  output cdc_mbox_pkg::chan_idx_t wb_adr_o,
  output cdc_mbox_pkg::data_t     wb_dat_o,
  input  logic                    wb_ack_i
);

  // Source domain links
  cdc_mbox_pkg::chan_vec_t load;
  cdc_mbox_pkg::chan_vec_t busy;
  cdc_mbox_pkg::data_t     disp_data;
  // Destination domain links
  cdc_mbox_pkg::chan_vec_t pending;
  cdc_mbox_pkg::chan_vec_t chan_ack;
  cdc_mbox_pkg::data_t [cdc_mbox_pkg::NumChannels-1:0] words;

  cdc_mbox_dispatcher #(
    .Depth (4)
  ) i_dispatcher (
    .clk_src_i   (clk_src_i),
    .rst_src_ni  (rst_src_ni),
    .src_valid_i (src_valid_i),
    .src_chan_i  (src_chan_i),
    .src_data_i  (src_data_i),
    .src_ready_o (src_ready_o),
    .load_o      (load),
    .data_o      (disp_data),
    .busy_i      (busy)
  );

  // One slot per channel, all sharing the dispatcher word
  for (genvar c = 0; c < cdc_mbox_pkg::NumChannels; c++) begin : g_chan
    cdc_mbox_channel i_channel (
      .clk_src_i  (clk_src_i),
      .rst_src_ni (rst_src_ni),
      .clk_dst_i  (clk_dst_i),
      .rst_dst_ni (rst_dst_ni),
      .load_i     (load[c]),
      .data_i     (disp_data),
      .busy_o     (busy[c]),
      .pending_o  (pending[c]),
      .word_o     (words[c]),
      .ack_i      (chan_ack[c])
    );
  end

  cdc_mbox_wb_drainer i_drainer (
    .clk_dst_i  (clk_dst_i),
    .rst_dst_ni (rst_dst_ni),
    .pending_i  (pending),
    .word_i     (words),
    .ack_o      (chan_ack),
    .wb_cyc_o   (wb_cyc_o),
    .wb_stb_o   (wb_stb_o),
    .wb_we_o    (wb_we_o),
    .wb_adr_o   (wb_adr_o),
    .wb_dat_o   (wb_dat_o),
    .wb_ack_i   (wb_ack_i)
  );

endmodule

`default_nettype wire

// File: verilog/cdc_mbox_wb_drainer.sv
`timescale 1ns/1ps
`default_nettype none

module cdc_mbox_wb_drainer (
  input  logic                    clk_dst_i,
  input  logic                    rst_dst_ni,
  // Channel side
  input  cdc_mbox_pkg::chan_vec_t pending_i,
  input  cdc_mbox_pkg::data_t [cdc_mbox_pkg::NumChannels-1:0] word_i,
  output cdc_mbox_pkg::chan_vec_t ack_o,
  // Wishbone classic master, writes only
  output logic                    wb_cyc_o,
  output logic                    wb_stb_o,
  output logic                    wb_we_o,
  output cdc_mbox_pkg::chan_idx_t wb_adr_o,
  output cdc_mbox_pkg::data_t     wb_dat_o,
  input  logic                    wb_ack_i
);

  typedef enum logic {
    IDLE,
    WRITE
  } drain_fsm_e;

  drain_fsm_e              state_q, state_d;
  cdc_mbox_pkg::chan_idx_t rr_q;
  cdc_mbox_pkg::chan_idx_t pick_idx;
  cdc_mbox_pkg::chan_idx_t adr_q;
  cdc_mbox_pkg::data_t     dat_q;
  logic                    pick_vld;
  logic                    start;
  logic                    done;

  // Round robin search, nearest pending slot after the last grant wins
  always_comb begin : rr_pick
    int cand;
    pick_vld = 1'b0;
    pick_idx = '0;
    for (int i = cdc_mbox_pkg::NumChannels; i >= 1; i--) begin
      cand = (int'(rr_q) + i) % cdc_mbox_pkg::NumChannels;
      if (pending_i[cand]) begin
        pick_vld = 1'b1;
        pick_idx = cdc_mbox_pkg::chan_idx_t'(cand);
      end
    end
  end

  assign start = (state_q == IDLE) && pick_vld;
  assign done  = (state_q == WRITE) && wb_ack_i;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (pick_vld) begin
          state_d = WRITE;
        end
      end
      WRITE: begin
        // Cycle ends on the edge after ack
        if (wb_ack_i) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_dst_i or negedge rst_dst_ni) begin
    if (!rst_dst_ni) begin
      state_q <= IDLE;
      // First search starts at channel 0
      rr_q    <= cdc_mbox_pkg::chan_idx_t'(cdc_mbox_pkg::NumChannels - 1);
    end else begin
      state_q <= state_d;
      if (done) begin
        rr_q <= adr_q;
      end
    end
  end

  // Address and word captured while the slot is pending
  always_ff @(posedge clk_dst_i) begin
    if (start) begin
      adr_q <= pick_idx;
      dat_q <= word_i[pick_idx];
    end
  end

  // ACK pulse to the granted slot in the bus ack cycle
  assign ack_o = done ? (cdc_mbox_pkg::chan_vec_t'(1) << adr_q) : '0;

  assign wb_cyc_o = (state_q == WRITE);
  assign wb_stb_o = (state_q == WRITE);
  assign wb_we_o  = (state_q == WRITE);
  assign wb_adr_o = adr_q;
  assign wb_dat_o = dat_q;

endmodule

`default_nettype wire

// File: verilog/prim_flop_2sync.sv
`timescale 1ns/1ps
`default_nettype none

module prim_flop_2sync #(
  parameter int Width = 1
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic [Width-1:0] d_i,
  output logic [Width-1:0] q_o
);

  // First stage may go metastable
  logic [Width-1:0] stage1_q;

  // Second stage gives a full cycle to settle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stage1_q <= '0;
      q_o      <= '0;
    end else begin
      stage1_q <= d_i;
      q_o      <= stage1_q;
    end
  end

endmodule

`default_nettype wire

// File: verilog/prim_sync_reqack.sv
`timescale 1ns/1ps
`default_nettype none

module prim_sync_reqack (
  // Requesting side
  input  logic clk_src_i,
  input  logic rst_src_ni,
  // Acknowledging side
  input  logic clk_dst_i,
  input  logic rst_dst_ni,

  // Level request, held by the source until acknowledged
  input  logic src_req_i,
  // Single-cycle handshake pulse back to the source
  output logic src_ack_o,
  // Request as seen by the destination
  output logic dst_req_o,
  // Destination accepts the request
  input  logic dst_ack_i
);

  typedef enum logic {
    HANDSHAKE,
    SYNC
  } reqack_fsm_e;

  reqack_fsm_e src_state_q, src_state_d;
  reqack_fsm_e dst_state_q, dst_state_d;

  // Wires that cross, and their synchronized copies
  logic src_req_d, src_req_q;
  logic dst_ack_d, dst_ack_q;
  logic req_synced;
  logic ack_synced;

  // Request level into the destination domain
  prim_flop_2sync #(
    .Width (1)
  ) i_req_sync (
    .clk_i  (clk_dst_i),
    .rst_ni (rst_dst_ni),
    .d_i    (src_req_q),
    .q_o    (req_synced)
  );

  // Acknowledge level back into the source domain
  prim_flop_2sync #(
    .Width (1)
  ) i_ack_sync (
    .clk_i  (clk_src_i),
    .rst_ni (rst_src_ni),
    .d_i    (dst_ack_q),
    .q_o    (ack_synced)
  );

  // Source side FSM
  always_comb begin
    src_state_d = src_state_q;
    // Pass the request on, ACK only while a request is held
    src_req_d   = src_req_i;
    src_ack_o   = src_req_i & ack_synced;
    unique case (src_state_q)
      HANDSHAKE: begin
        // One-cycle handshake, then drop the request level
        if (src_req_i && ack_synced) begin
          src_state_d = SYNC;
          src_req_d   = 1'b0;
        end
      end
      SYNC: begin
        // Hold request low until the ACK level has returned to zero
        src_req_d = 1'b0;
        src_ack_o = 1'b0;
        if (!ack_synced) begin
          src_state_d = HANDSHAKE;
        end
      end
      default: begin
        src_state_d = HANDSHAKE;
      end
    endcase
  end

  // Destination side FSM
  always_comb begin
    dst_state_d = dst_state_q;
    dst_req_o   = req_synced;
    // ACK level only rises for a request that is really there
    dst_ack_d   = req_synced & dst_ack_i;
    unique case (dst_state_q)
      HANDSHAKE: begin
        // Request taken on the cycle the ACK comes in
        if (req_synced && dst_ack_i) begin
          dst_state_d = SYNC;
        end
      end
      SYNC: begin
        // Mask the stale request, keep ACK high until it falls
        dst_req_o = 1'b0;
        dst_ack_d = 1'b1;
        if (!req_synced) begin
          dst_state_d = HANDSHAKE;
        end
      end
      default: begin
        dst_state_d = HANDSHAKE;
      end
    endcase
  end

  always_ff @(posedge clk_src_i or negedge rst_src_ni) begin
    if (!rst_src_ni) begin
      src_state_q <= HANDSHAKE;
      src_req_q   <= 1'b0;
    end else begin
      src_state_q <= src_state_d;
      src_req_q   <= src_req_d;
    end
  end

  always_ff @(posedge clk_dst_i or negedge rst_dst_ni) begin
    if (!rst_dst_ni) begin
      dst_state_q <= HANDSHAKE;
      dst_ack_q   <= 1'b0;
    end else begin
      dst_state_q <= dst_state_d;
      dst_ack_q   <= dst_ack_d;
    end
  end

endmodule

`default_nettype wire
